/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_icache_tag_ctrl
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/icache_pkg.sv */
package icache_pkg;

    // ==============================
    // address geometry
    // ==============================
    localparam int OFFSET_W = 6;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 8;
    localparam int TXNID_W  = 4;
    localparam int WAY_NUM  = 2;
    localparam int WAY_W    = $clog2(WAY_NUM);
    localparam int SET_NUM  = 1 << INDEX_W;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    typedef struct packed {
        fetch_addr_t        addr;
        logic [TXNID_W-1:0] txnid;
    } fetch_req_t;

    // ==============================
    // tag memory word
    // ==============================
    typedef struct packed {
        logic             vld;
        logic [TAG_W-1:0] tag;
    } tag_way_t;

    typedef struct packed {
        tag_way_t way1;
        tag_way_t way0;
    } tag_set_t;

    // tag above index so a +1 on the line carries into the tag
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } bank_lookup_t;

    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] way;
    } bank_hit_t;

    typedef struct packed {
        logic               vld;
        logic [INDEX_W-1:0] index;
        tag_set_t           tags;
    } refill_slot_t;

    // hit_x is one-hot per way, way_x is the destination way
    typedef struct packed {
        logic [WAY_NUM-1:0] hit_a;
        logic [WAY_W-1:0]   way_a;
        logic [WAY_NUM-1:0] hit_b;
        logic [WAY_W-1:0]   way_b;
        logic [INDEX_W-1:0] index_a;
        logic [INDEX_W-1:0] index_b;
        logic [TXNID_W-1:0] txnid;
        logic               bypass;
    } lookup_result_t;

    // a pending refill slot at the same index is newer than the memory word
    function automatic tag_set_t pick_set(bank_lookup_t look, tag_set_t rd_set,
                                          refill_slot_t slot_a, refill_slot_t slot_b);
        tag_set_t sel;
        sel = rd_set;
        if (slot_b.vld && (slot_b.index == look.index)) begin
            sel = slot_b.tags;
        end
        if (slot_a.vld && (slot_a.index == look.index)) begin
            sel = slot_a.tags;
        end
        return sel;
    endfunction

endpackage

/* files.f */
common/icache_pkg.sv
tag_lookup/tag_store.sv
tag_lookup/tag_compare.sv
tag_lookup/lru_table.sv
refill/refill_buffer.sv
src/fetch_decode.sv
src/lookup_result.sv
src/icache_tag_ctrl.sv
sim/icache_tag_ctrl_props.sv
sim/tb_icache_tag_ctrl.sv

/* refill/refill_buffer.sv */
`timescale 1ns/1ps

module refill_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           look_vld,
    input  icache_pkg::bank_lookup_t       look_a,
    input  icache_pkg::bank_lookup_t       look_b,
    input  icache_pkg::tag_set_t           set_a,
    input  icache_pkg::tag_set_t           set_b,
    input  icache_pkg::bank_hit_t          hit_a,
    input  icache_pkg::bank_hit_t          hit_b,
    input  logic                           victim_a,
    input  logic                           victim_b,
    output icache_pkg::refill_slot_t       slot_a,
    output icache_pkg::refill_slot_t       slot_b,
    output logic                           pending,
    output logic                           wr_en,
    output logic [icache_pkg::INDEX_W-1:0] wr_idx,
    output icache_pkg::tag_set_t           wr_set
);

    logic                     load_a;
    logic                     load_b;
    logic                     drain_a;
    logic                     drain_b;
    icache_pkg::refill_slot_t new_a;
    icache_pkg::refill_slot_t new_b;

    // new tag goes into the victim way, the other way is kept
    function automatic icache_pkg::tag_set_t fill_set(icache_pkg::tag_set_t base,
                                                      logic [icache_pkg::TAG_W-1:0] tag,
                                                      logic victim);
        icache_pkg::tag_set_t s;
        s = base;
        if (victim) begin
            s.way1.vld = 1'b1;
            s.way1.tag = tag;
        end else begin
            s.way0.vld = 1'b1;
            s.way0.tag = tag;
        end
        return s;
    endfunction

    // ==============================
    // slot load
    // ==============================
    // same line in both banks refills once, through A
    assign load_a = look_vld && !hit_a.hit;
    assign load_b = look_vld && !hit_b.hit && (look_a != look_b);

    assign new_a = '{vld: 1'b1, index: look_a.index,
                     tags: fill_set(set_a, look_a.tag, victim_a)};
    assign new_b = '{vld: 1'b1, index: look_b.index,
                     tags: fill_set(set_b, look_b.tag, victim_b)};

    // ==============================
    // drain, A before B
    // ==============================
    assign drain_a = slot_a.vld;
    assign drain_b = slot_b.vld && !slot_a.vld;

    assign pending = slot_a.vld | slot_b.vld;
    assign wr_en   = pending;
    assign wr_idx  = slot_a.vld ? slot_a.index : slot_b.index;
    assign wr_set  = slot_a.vld ? slot_a.tags : slot_b.tags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_a <= '0;
            slot_b <= '0;
        end else begin
            if (load_a) begin
                slot_a <= new_a;
            end else if (drain_a) begin
                slot_a.vld <= 1'b0;
            end
            if (load_b) begin
                slot_b <= new_b;
            end else if (drain_b) begin
                slot_b.vld <= 1'b0;
            end
        end
    end

endmodule

/* sim/icache_tag_ctrl_props.sv */
`timescale 1ns/1ps

module icache_tag_ctrl_props (
    input logic clk,
    input logic rst_n,
    input logic req_rdy,
    input logic pending,
    input logic wr_en,
    input logic slot_a_vld,
    input logic slot_b_vld
);

    int err_cnt = 0;

    // at most two refill writes per fetch
    wr_burst: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && $past(wr_en) |-> !$past(wr_en, 2))
        else begin
            err_cnt++;
            $error("wr_en high for more than two cycles");
        end

    // slot A is written first
    drain_order: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(slot_b_vld) |-> !$past(slot_a_vld))
        else begin
            err_cnt++;
            $error("slot B drained while slot A was pending");
        end

    no_accept_pending: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !req_rdy)
        else begin
            err_cnt++;
            $error("req_rdy high during a pending refill");
        end

endmodule

/* sim/tb_icache_tag_ctrl.sv */
`timescale 1ns/1ps

module tb_icache_tag_ctrl;

    localparam int TIMEOUT  = 50;
    localparam int RAND_NUM = 24;

    typedef struct packed {
        icache_pkg::fetch_req_t req;
        logic                   chain;
    } stim_t;

    logic                           clk;
    logic                           rst_n;
    logic                           req_vld;
    icache_pkg::fetch_req_t         req;
    logic                           req_rdy;
    logic                           res_vld;
    icache_pkg::lookup_result_t     res;

    stim_t                          stim [$];
    string                          stim_name [$];
    icache_pkg::tag_set_t           model_set [icache_pkg::SET_NUM];
    logic [icache_pkg::SET_NUM-1:0] model_lru;
    integer                         seed;
    int                             checks;
    int                             errors;
    bit                             timed_out;

    icache_tag_ctrl icache_tag_ctrl_inst (
        .clk(clk), .rst_n(rst_n), .req_vld(req_vld), .req(req), .req_rdy(req_rdy),
        .res_vld(res_vld), .res(res)
    );

    bind icache_tag_ctrl icache_tag_ctrl_props props_inst (
        .clk(clk), .rst_n(rst_n), .req_rdy(req_rdy), .pending(pending), .wr_en(wr_en),
        .slot_a_vld(slot_a.vld), .slot_b_vld(slot_b.vld)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void add_fetch(input string name, input logic [icache_pkg::TAG_W-1:0] tag,
                                      input logic [icache_pkg::INDEX_W-1:0] index,
                                      input logic [icache_pkg::OFFSET_W-1:0] offset,
                                      input logic chain);
        stim_t s;
        int    n;
        n = stim.size();
        s.req.addr.tag    = tag;
        s.req.addr.index  = index;
        s.req.addr.offset = offset;
        s.req.txnid       = n[icache_pkg::TXNID_W-1:0];
        s.chain           = chain;
        stim.push_back(s);
        stim_name.push_back(name);
    endfunction

    // ==============================
    // reference model
    // ==============================
    // bank B looks at the next line (address plus one line) unless the offset is all ones
    function automatic icache_pkg::lookup_result_t model_fetch(
        input icache_pkg::fetch_req_t r, output icache_pkg::bank_hit_t exp_a,
        output icache_pkg::bank_hit_t exp_b, output int writes);
        logic [$bits(icache_pkg::fetch_addr_t)-1:0] line_size;
        icache_pkg::fetch_addr_t       next;
        logic [icache_pkg::INDEX_W-1:0] idx [2];
        logic [icache_pkg::TAG_W-1:0]   tag [2];
        icache_pkg::tag_set_t           set [2];
        logic                           hit [2];
        logic                           way [2];
        logic                           same;
        icache_pkg::lookup_result_t     e;
        line_size = '0;
        line_size[icache_pkg::OFFSET_W] = 1'b1;
        next = r.addr + line_size;
        same = (r.addr.offset == '1);
        idx[0] = r.addr.index;
        tag[0] = r.addr.tag;
        idx[1] = same ? r.addr.index : next.index;
        tag[1] = same ? r.addr.tag : next.tag;
        for (int b = 0; b < 2; b++) begin
            set[b] = model_set[idx[b]];
            hit[b] = 1'b1;
            if (set[b].way0.vld && (set[b].way0.tag == tag[b])) begin
                way[b] = 1'b0;
            end else if (set[b].way1.vld && (set[b].way1.tag == tag[b])) begin
                way[b] = 1'b1;
            end else begin
                hit[b] = 1'b0;
                // empty way 0, then empty way 1, then the LRU bit
                way[b] = !set[b].way0.vld ? 1'b0 : (!set[b].way1.vld ? 1'b1 : model_lru[idx[b]]);
            end
        end
        // bank A last, it wins a shared index
        model_lru[idx[1]] = ~way[1];
        model_lru[idx[0]] = ~way[0];
        writes = 0;
        for (int b = 0; b < 2; b++) begin
            if (!hit[b] && !(b == 1 && same)) begin
                if (way[b]) begin
                    model_set[idx[b]].way1 = '{vld: 1'b1, tag: tag[b]};
                end else begin
                    model_set[idx[b]].way0 = '{vld: 1'b1, tag: tag[b]};
                end
                writes++;
            end
        end
        exp_a     = '{hit: hit[0], way: way[0]};
        exp_b     = '{hit: hit[1], way: way[1]};
        e.hit_a   = hit[0] ? (way[0] ? 2'b10 : 2'b01) : 2'b00;
        e.way_a   = way[0];
        e.hit_b   = hit[1] ? (way[1] ? 2'b10 : 2'b01) : 2'b00;
        e.way_b   = way[1];
        e.index_a = idx[0];
        e.index_b = idx[1];
        e.txnid   = r.txnid;
        e.bypass  = hit[0] && hit[1];
        return e;
    endfunction

    task automatic build_table();
        logic [31:0] r;
        add_fetch("cold miss", 8'h10, 6'd2, 6'd0, 1'b0);
        add_fetch("cold hit", 8'h10, 6'd2, 6'd0, 1'b0);
        // index 63, next line carries into the tag
        add_fetch("split miss", 8'h20, 6'd63, 6'd5, 1'b0);
        add_fetch("split hit", 8'h20, 6'd63, 6'd5, 1'b0);
        // one line in both banks, three tags at one set
        add_fetch("lru fill way 0", 8'h31, 6'd20, 6'd63, 1'b0);
        add_fetch("lru fill way 1", 8'h32, 6'd20, 6'd63, 1'b0);
        add_fetch("lru replace", 8'h33, 6'd20, 6'd63, 1'b0);
        add_fetch("lru evicted tag", 8'h31, 6'd20, 6'd63, 1'b0);
        add_fetch("lru kept tag", 8'h33, 6'd20, 6'd63, 1'b0);
        // bank B finds the cold miss line
        add_fetch("partial hit", 8'h10, 6'd1, 6'd0, 1'b0);
        add_fetch("back-to-back miss", 8'h44, 6'd40, 6'd3, 1'b0);
        add_fetch("back-to-back forward", 8'h44, 6'd40, 6'd3, 1'b1);
        for (int k = 0; k < RAND_NUM; k++) begin
            r = $random(seed);
            add_fetch("random", 8'h50 + 8'(r[1:0]), 6'd8 + 6'(r[3:2]),
                      (r[11:10] == 2'b11) ? 6'h3f : r[9:4], 1'b0);
        end
    endtask

    // ==============================
    // waits and compares
    // ==============================
    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (!req_rdy && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: req_rdy stayed low for %0d cycles", TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!res_vld && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no res_vld within %0d cycles", TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_result(input int n, input icache_pkg::lookup_result_t got,
                                input icache_pkg::lookup_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: fetch %0d result %h, expected %h", $time, n, got, exp);
        end
    endtask

    task automatic check_hit(input int n, input string bank, input icache_pkg::bank_hit_t got,
                             input icache_pkg::bank_hit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: fetch %0d bank %s hit %b way %b, expected hit %b way %b",
                     $time, n, bank, got.hit, got.way, exp.hit, exp.way);
        end
    endtask

    task automatic check_stall(input int n, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: fetch %0d held req_rdy low %0d cycles, expected %0d",
                     $time, n, got, exp);
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int                         i;
        int                         n;
        int                         stall;
        int                         writes;
        int                         err_before;
        icache_pkg::bank_hit_t      ha;
        icache_pkg::bank_hit_t      hb;
        icache_pkg::bank_hit_t      got_h;
        icache_pkg::lookup_result_t exp_r;
        icache_pkg::lookup_result_t exp_res [$];
        icache_pkg::bank_hit_t      exp_ha [$];
        icache_pkg::bank_hit_t      exp_hb [$];
        req_vld   = 1'b0;
        req       = '0;
        rst_n     = 1'b0;
        seed      = 32'hd993f184;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        model_lru = '0;
        for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
            model_set[s] = '0;
        end
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        wait_ready(stall);
        i = 0;
        while (i < stim.size() && !timed_out) begin
            n = 0;
            err_before = errors;
            @(posedge clk);
            // chained entries go out in consecutive cycles
            do begin
                req_vld <= 1'b1;
                req     <= stim[i + n].req;
                exp_r = model_fetch(stim[i + n].req, ha, hb, writes);
                exp_res.push_back(exp_r);
                exp_ha.push_back(ha);
                exp_hb.push_back(hb);
                @(posedge clk);
                n++;
            end while ((i + n) < stim.size() && stim[i + n].chain);
            req_vld <= 1'b0;
            for (int k = 0; k < n && !timed_out; k++) begin
                wait_result();
                if (!timed_out) begin
                    check_result(i + k, res, exp_res[k]);
                    got_h = '{hit: |res.hit_a, way: res.way_a};
                    check_hit(i + k, "A", got_h, exp_ha[k]);
                    got_h = '{hit: |res.hit_b, way: res.way_b};
                    check_hit(i + k, "B", got_h, exp_hb[k]);
                end
            end
            if (!timed_out) begin
                wait_ready(stall);
                // one refused cycle per refill write
                if (n == 1 && !timed_out) begin
                    check_stall(i, stall, writes);
                end
            end
            $display("test %0d %s: %s", i, stim_name[i],
                     (errors == err_before && !timed_out) ? "ok" : "errors");
            exp_res.delete();
            exp_ha.delete();
            exp_hb.delete();
            i += n;
        end
        errors += icache_tag_ctrl_inst.props_inst.err_cnt;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* src/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_vld,
    input  icache_pkg::fetch_req_t         req,
    output logic                           req_rdy,
    input  logic                           wr_en,
    input  logic                           pending,
    output logic                           rd_en,
    output logic [icache_pkg::INDEX_W-1:0] rd_idx_a,
    output logic [icache_pkg::INDEX_W-1:0] rd_idx_b,
    output logic                           look_vld,
    output icache_pkg::bank_lookup_t       look_a,
    output icache_pkg::bank_lookup_t       look_b,
    output logic [icache_pkg::TXNID_W-1:0] look_txnid
);

    logic                     accept;
    logic                     one_line;
    icache_pkg::bank_lookup_t cur_line;
    icache_pkg::bank_lookup_t next_line;
    icache_pkg::bank_lookup_t line_b;

    // ==============================
    // handshake
    // ==============================
    assign req_rdy = ~(pending | wr_en);
    assign accept  = req_vld & req_rdy;
    assign rd_en   = accept;

    // ==============================
    // bank address derivation
    // ==============================
    // last offset of the line, so the fetch never crosses into the next one
    assign one_line = &req.addr.offset;

    assign cur_line.tag   = req.addr.tag;
    assign cur_line.index = req.addr.index;
    // index wraps into the tag
    assign next_line = cur_line + 1'b1;
    assign line_b    = one_line ? cur_line : next_line;

    assign rd_idx_a = cur_line.index;
    assign rd_idx_b = line_b.index;

    // lookup stage lines up with the memory output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            look_vld <= 1'b0;
        end else begin
            look_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            look_a     <= cur_line;
            look_b     <= line_b;
            look_txnid <= req.txnid;
        end
    end

endmodule

/* src/icache_tag_ctrl.sv */
`timescale 1ns/1ps

module icache_tag_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_vld,
    input  icache_pkg::fetch_req_t     req,
    output logic                       req_rdy,
    output logic                       res_vld,
    output icache_pkg::lookup_result_t res
);

    logic                                rd_en;
    logic [icache_pkg::INDEX_W-1:0]      rd_idx_a;
    logic [icache_pkg::INDEX_W-1:0]      rd_idx_b;
    logic                                look_vld;
    icache_pkg::bank_lookup_t            look_a;
    icache_pkg::bank_lookup_t            look_b;
    logic [icache_pkg::TXNID_W-1:0]      look_txnid;
    logic                                wr_en;
    logic                                pending;
    logic [icache_pkg::INDEX_W-1:0]      wr_idx;
    icache_pkg::tag_set_t                wr_set;
    logic                                mem_en;
    logic [icache_pkg::INDEX_W-1:0]      addr_a;
    logic [icache_pkg::INDEX_W-1:0]      addr_b;
    icache_pkg::tag_set_t                rd_set_a;
    icache_pkg::tag_set_t                rd_set_b;
    icache_pkg::tag_set_t                set_a;
    icache_pkg::tag_set_t                set_b;
    icache_pkg::refill_slot_t            slot_a;
    icache_pkg::refill_slot_t            slot_b;
    icache_pkg::bank_hit_t               hit_a;
    icache_pkg::bank_hit_t               hit_b;
    icache_pkg::bank_hit_t               dest_a;
    icache_pkg::bank_hit_t               dest_b;
    logic                                victim_a;
    logic                                victim_b;

    // refill writes own the shared address port
    assign mem_en = rd_en | wr_en;
    assign addr_a = wr_en ? wr_idx : rd_idx_a;
    assign addr_b = wr_en ? wr_idx : rd_idx_b;

    // set as seen after forwarding, for victim pick and new set build
    assign set_a = icache_pkg::pick_set(look_a, rd_set_a, slot_a, slot_b);
    assign set_b = icache_pkg::pick_set(look_b, rd_set_b, slot_a, slot_b);

    // destination way: hit way, or victim on a miss
    assign dest_a.hit = hit_a.hit;
    assign dest_a.way = hit_a.hit ? hit_a.way : victim_a;
    assign dest_b.hit = hit_b.hit;
    assign dest_b.way = hit_b.hit ? hit_b.way : victim_b;

    fetch_decode fetch_decode_inst (
        .clk(clk), .rst_n(rst_n), .req_vld(req_vld), .req(req), .req_rdy(req_rdy),
        .wr_en(wr_en), .pending(pending), .rd_en(rd_en),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .look_vld(look_vld),
        .look_a(look_a), .look_b(look_b), .look_txnid(look_txnid)
    );

    tag_store bank_a_store (
        .clk(clk), .en(mem_en), .wr_en(wr_en), .addr(addr_a),
        .wr_set(wr_set), .rd_set(rd_set_a)
    );

    tag_store bank_b_store (
        .clk(clk), .en(mem_en), .wr_en(wr_en), .addr(addr_b),
        .wr_set(wr_set), .rd_set(rd_set_b)
    );

    tag_compare cmp_a (
        .look(look_a), .rd_set(rd_set_a), .slot_a(slot_a), .slot_b(slot_b), .hit(hit_a)
    );

    tag_compare cmp_b (
        .look(look_b), .rd_set(rd_set_b), .slot_a(slot_a), .slot_b(slot_b), .hit(hit_b)
    );

    lru_table lru_table_inst (
        .clk(clk), .rst_n(rst_n), .look_vld(look_vld), .look_a(look_a), .look_b(look_b),
        .set_a(set_a), .set_b(set_b), .hit_a(hit_a), .hit_b(hit_b),
        .victim_a(victim_a), .victim_b(victim_b)
    );

    refill_buffer refill_buffer_inst (
        .clk(clk), .rst_n(rst_n), .look_vld(look_vld), .look_a(look_a), .look_b(look_b),
        .set_a(set_a), .set_b(set_b), .hit_a(hit_a), .hit_b(hit_b),
        .victim_a(victim_a), .victim_b(victim_b), .slot_a(slot_a), .slot_b(slot_b),
        .pending(pending), .wr_en(wr_en), .wr_idx(wr_idx), .wr_set(wr_set)
    );

    lookup_result lookup_result_inst (
        .clk(clk), .rst_n(rst_n), .look_vld(look_vld), .look_a(look_a), .look_b(look_b),
        .look_txnid(look_txnid), .hit_a(dest_a), .hit_b(dest_b),
        .res_vld(res_vld), .res(res)
    );

endmodule

/* src/lookup_result.sv */
`timescale 1ns/1ps

module lookup_result (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           look_vld,
    input  icache_pkg::bank_lookup_t       look_a,
    input  icache_pkg::bank_lookup_t       look_b,
    input  logic [icache_pkg::TXNID_W-1:0] look_txnid,
    input  icache_pkg::bank_hit_t          hit_a,
    input  icache_pkg::bank_hit_t          hit_b,
    output logic                           res_vld,
    output icache_pkg::lookup_result_t     res
);

    icache_pkg::lookup_result_t res_d;

    // all zero on a miss
    function automatic logic [icache_pkg::WAY_NUM-1:0] way_onehot(icache_pkg::bank_hit_t h);
        logic [icache_pkg::WAY_NUM-1:0] oh;
        oh = '0;
        for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
            oh[w] = h.hit && (int'(h.way) == w);
        end
        return oh;
    endfunction

    always_comb begin
        res_d.hit_a   = way_onehot(hit_a);
        res_d.way_a   = hit_a.way;
        res_d.hit_b   = way_onehot(hit_b);
        res_d.way_b   = hit_b.way;
        res_d.index_a = look_a.index;
        res_d.index_b = look_b.index;
        res_d.txnid   = look_txnid;
        // data RAM can be read straight away only when both lines are present
        res_d.bypass  = hit_a.hit & hit_b.hit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= 1'b0;
        end else begin
            res_vld <= look_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (look_vld) begin
            res <= res_d;
        end
    end

endmodule

/* tag_lookup/lru_table.sv */
`timescale 1ns/1ps

module lru_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     look_vld,
    input  icache_pkg::bank_lookup_t look_a,
    input  icache_pkg::bank_lookup_t look_b,
    input  icache_pkg::tag_set_t     set_a,
    input  icache_pkg::tag_set_t     set_b,
    input  icache_pkg::bank_hit_t    hit_a,
    input  icache_pkg::bank_hit_t    hit_b,
    output logic                     victim_a,
    output logic                     victim_b
);

    logic [icache_pkg::SET_NUM-1:0] lru;
    logic                           next_a;
    logic                           next_b;

    // empty ways fill first, way 0 before way 1
    function automatic logic pick_victim(icache_pkg::tag_set_t s, logic lru_bit);
        logic v;
        if (!s.way0.vld) begin
            v = 1'b0;
        end else if (!s.way1.vld) begin
            v = 1'b1;
        end else begin
            v = lru_bit;
        end
        return v;
    endfunction

    assign victim_a = pick_victim(set_a, lru[look_a.index]);
    assign victim_b = pick_victim(set_b, lru[look_b.index]);

    // point away from the way just used
    assign next_a = hit_a.hit ? ~hit_a.way : ~victim_a;
    assign next_b = hit_b.hit ? ~hit_b.way : ~victim_b;

    // A is written last so it wins on a shared index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (look_vld) begin
            lru[look_b.index] <= next_b;
            lru[look_a.index] <= next_a;
        end
    end

endmodule

/* tag_lookup/tag_compare.sv */
`timescale 1ns/1ps

module tag_compare (
    input  icache_pkg::bank_lookup_t look,
    input  icache_pkg::tag_set_t     rd_set,
    input  icache_pkg::refill_slot_t slot_a,
    input  icache_pkg::refill_slot_t slot_b,
    output icache_pkg::bank_hit_t    hit
);

    icache_pkg::tag_set_t cur_set;
    logic                 match0;
    logic                 match1;

    // memory word may be stale while a refill to this index is pending
    assign cur_set = icache_pkg::pick_set(look, rd_set, slot_a, slot_b);

    // ==============================
    // way match
    // ==============================
    assign match0 = cur_set.way0.vld && (cur_set.way0.tag == look.tag);
    assign match1 = cur_set.way1.vld && (cur_set.way1.tag == look.tag);

    // way 0 takes priority on a double match
    always_comb begin
        hit.hit = match0 | match1;
        hit.way = !match0 && match1;
    end

endmodule

/* tag_lookup/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           wr_en,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  icache_pkg::tag_set_t           wr_set,
    output icache_pkg::tag_set_t           rd_set
);

    icache_pkg::tag_set_t mem [icache_pkg::SET_NUM];

    // all ways start out invalid
    initial begin
        for (int i = 0; i < icache_pkg::SET_NUM; i++) begin
            mem[i] = '0;
        end
    end

    // single port, write has no read data
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[addr] <= wr_set;
            end else begin
                rd_set <= mem[addr];
            end
        end
    end

endmodule
